/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

    // Major opcodes of the base integer ISA
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_I_ALU  = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_R      = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // ALU funct3 groups, shared by R-type and I-type
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // funct7, alternate selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

/* src/core_ctrl_pkg.sv */
package core_ctrl_pkg;

    // Operation performed by the execute ALU
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB    = 4'b0001,
        ALU_AND    = 4'b0010,
        ALU_OR     = 4'b0011,
        ALU_SLL    = 4'b0100,
        ALU_SLT    = 4'b0101,
        ALU_SRL    = 4'b0110,
        ALU_SLTU   = 4'b0111,
        ALU_XOR    = 4'b1000,
        ALU_SRA    = 4'b1001,
        ALU_PASS_B = 4'b1010
    } alu_ctrl_e;

    // Class handed from the main decoder to the ALU decoder
    typedef enum logic [1:0] {
        ALU_OP_ADD    = 2'b00,
        ALU_OP_BRANCH = 2'b01,
        ALU_OP_MATH   = 2'b10
    } alu_op_e;

    // Immediate formats
    typedef enum logic [1:0] {
        IMM_I,
        IMM_B,
        IMM_J,
        IMM_U
    } imm_sel_e;

    // Writeback source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_PC4,
        WB_UPPER
    } wb_sel_e;

    // Base operand of the target adder
    typedef enum logic [1:0] {
        TGT_PC,
        TGT_ZERO,
        TGT_RS1
    } target_sel_e;

endpackage

/* src/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
#(
    parameter int REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output logic [4:0]  rs1_addr,
    output logic [4:0]  rs2_addr,
    output logic        ex_valid,
    output logic        ex_illegal,
    output alu_ctrl_e   ex_alu_ctrl,
    output logic        ex_use_imm,
    output logic [31:0] ex_imm,
    output wb_sel_e     ex_wb_sel,
    output target_sel_e ex_target_sel,
    output logic        ex_branch,
    output logic        ex_jump,
    output logic [2:0]  ex_branch_f3,
    output logic        ex_reg_write,
    output logic [4:0]  ex_rd,
    output logic [31:0] ex_pc,
    output logic [31:0] ex_rs1,
    output logic [31:0] ex_rs2
);

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rd;
    alu_op_e     alu_op;
    alu_ctrl_e   alu_ctrl;
    imm_sel_e    imm_sel;
    wb_sel_e     wb_sel;
    target_sel_e target_sel;
    logic        op_legal;
    logic        dec_reg_write;
    logic        use_imm;
    logic        branch;
    logic        jump;
    logic        uses_rs1;
    logic        uses_rs2;
    logic        bad_reg;
    logic        illegal;
    logic [31:0] imm;

    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rd       = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Main decoder
    always_comb begin
        op_legal      = 1'b1;
        dec_reg_write = 1'b0;
        use_imm       = 1'b0;
        alu_op        = ALU_OP_ADD;
        imm_sel       = IMM_I;
        wb_sel        = WB_ALU;
        target_sel    = TGT_PC;
        branch        = 1'b0;
        jump          = 1'b0;
        uses_rs1      = 1'b0;
        uses_rs2      = 1'b0;
        case (opcode)
            OPC_R: begin
                dec_reg_write = 1'b1;
                alu_op        = ALU_OP_MATH;
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
            end
            OPC_I_ALU: begin
                dec_reg_write = 1'b1;
                use_imm       = 1'b1;
                alu_op        = ALU_OP_MATH;
                uses_rs1      = 1'b1;
                // Shift immediates keep a funct7 above the 5-bit shamt
                if (funct3 == F3_SLL) begin
                    op_legal = (funct7 == F7_BASE);
                end else if (funct3 == F3_SRL_SRA) begin
                    op_legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                end
            end
            OPC_BRANCH: begin
                imm_sel  = IMM_B;
                alu_op   = ALU_OP_BRANCH;
                branch   = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OPC_JAL: begin
                dec_reg_write = 1'b1;
                imm_sel       = IMM_J;
                wb_sel        = WB_PC4;
                jump          = 1'b1;
            end
            OPC_JALR: begin
                dec_reg_write = 1'b1;
                wb_sel        = WB_PC4;
                target_sel    = TGT_RS1;
                jump          = 1'b1;
                uses_rs1      = 1'b1;
            end
            OPC_LUI: begin
                dec_reg_write = 1'b1;
                imm_sel       = IMM_U;
                wb_sel        = WB_UPPER;
                target_sel    = TGT_ZERO;
            end
            OPC_AUIPC: begin
                dec_reg_write = 1'b1;
                imm_sel       = IMM_U;
                wb_sel        = WB_UPPER;
            end
            // No data memory or CSR file behind this slice
            OPC_LOAD, OPC_STORE, OPC_SYSTEM: op_legal = 1'b0;
            default: op_legal = 1'b0;
        endcase
    end

    // Register indices beyond the implemented file, e.g. x16+ on RV32E
    assign bad_reg = (uses_rs1 && int'(rs1_addr) >= REG_COUNT)
                  || (uses_rs2 && int'(rs2_addr) >= REG_COUNT)
                  || (dec_reg_write && int'(rd) >= REG_COUNT);
    assign illegal = !op_legal || bad_reg;

    // ALU decoder
    always_comb begin
        case (alu_op)
            ALU_OP_ADD: alu_ctrl = ALU_ADD;
            ALU_OP_MATH: begin
                case (funct3)
                    F3_ADD_SUB: begin
                        // ADDI has no SUB form
                        if (opcode == OPC_R && funct7 == F7_ALT) begin
                            alu_ctrl = ALU_SUB;
                        end else begin
                            alu_ctrl = ALU_ADD;
                        end
                    end
                    F3_SLL:     alu_ctrl = ALU_SLL;
                    F3_SLT:     alu_ctrl = ALU_SLT;
                    F3_SLTU:    alu_ctrl = ALU_SLTU;
                    F3_XOR:     alu_ctrl = ALU_XOR;
                    F3_SRL_SRA: alu_ctrl = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      alu_ctrl = ALU_OR;
                    default:    alu_ctrl = ALU_AND;
                endcase
            end
            ALU_OP_BRANCH: begin
                case (funct3)
                    F3_BEQ, F3_BNE:   alu_ctrl = ALU_SUB;
                    F3_BLT, F3_BGE:   alu_ctrl = ALU_SLT;
                    F3_BLTU, F3_BGEU: alu_ctrl = ALU_SLTU;
                    default:          alu_ctrl = ALU_PASS_B;
                endcase
            end
            default: alu_ctrl = ALU_PASS_B;
        endcase
    end

    // Immediate generator, sign taken from instr[31]
    always_comb begin
        case (imm_sel)
            IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            IMM_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            IMM_U:   imm = {instr[31:12], 12'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // Issue register, control qualified by the strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid     <= 1'b0;
            ex_illegal   <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_branch    <= 1'b0;
            ex_jump      <= 1'b0;
        end else begin
            ex_valid     <= instr_valid;
            ex_illegal   <= instr_valid && illegal;
            ex_reg_write <= instr_valid && dec_reg_write && !illegal;
            ex_branch    <= instr_valid && branch && !illegal;
            ex_jump      <= instr_valid && jump && !illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ex_alu_ctrl   <= alu_ctrl;
            ex_use_imm    <= use_imm;
            ex_imm        <= imm;
            ex_wb_sel     <= wb_sel;
            ex_target_sel <= target_sel;
            ex_branch_f3  <= funct3;
            ex_rd         <= rd;
            ex_pc         <= pc;
            ex_rs1        <= rs1_data;
            ex_rs2        <= rs2_data;
        end
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/10ps

module reg_file #(
    parameter int REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic        wb_en,
    input  logic [4:0]  wb_addr,
    input  logic [31:0] wb_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [REG_COUNT];
    logic        wr_ok;

    // x0 never takes a write
    assign wr_ok = wb_en && (wb_addr != 5'd0) && (int'(wb_addr) < REG_COUNT);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Bypass the write of this cycle onto a matching read
    always_comb begin
        if (rs1_addr == 5'd0 || int'(rs1_addr) >= REG_COUNT) begin
            rs1_data = '0;
        end else if (wr_ok && wb_addr == rs1_addr) begin
            rs1_data = wb_data;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    always_comb begin
        if (rs2_addr == 5'd0 || int'(rs2_addr) >= REG_COUNT) begin
            rs2_data = '0;
        end else if (wr_ok && wb_addr == rs2_addr) begin
            rs2_data = wb_data;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

/* src/exec_unit.sv */
`timescale 1ns/10ps

module exec_unit
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        ex_valid,
    input  logic        ex_illegal,
    input  alu_ctrl_e   ex_alu_ctrl,
    input  logic        ex_use_imm,
    input  logic [31:0] ex_imm,
    input  wb_sel_e     ex_wb_sel,
    input  target_sel_e ex_target_sel,
    input  logic        ex_branch,
    input  logic        ex_jump,
    input  logic [2:0]  ex_branch_f3,
    input  logic        ex_reg_write,
    input  logic [4:0]  ex_rd,
    input  logic [31:0] ex_pc,
    input  logic [31:0] ex_rs1,
    input  logic [31:0] ex_rs2,
    output logic        wb_en,
    output logic [4:0]  wb_addr,
    output logic [31:0] wb_data,
    output logic        result_valid,
    output logic [4:0]  result_rd,
    output logic [31:0] result_data,
    output logic        reg_write,
    output logic        branch_taken,
    output logic [31:0] next_pc,
    output logic        illegal
);

    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic        alu_last_bit;
    logic        taken;
    logic [31:0] target_base;
    logic [31:0] target_sum;
    logic [31:0] target;
    logic [31:0] pc_plus4;

    assign alu_b = ex_use_imm ? ex_imm : ex_rs2;

    always_comb begin
        case (ex_alu_ctrl)
            ALU_ADD:  alu_result = ex_rs1 + alu_b;
            ALU_SUB:  alu_result = ex_rs1 - alu_b;
            ALU_AND:  alu_result = ex_rs1 & alu_b;
            ALU_OR:   alu_result = ex_rs1 | alu_b;
            ALU_XOR:  alu_result = ex_rs1 ^ alu_b;
            ALU_SLT:  alu_result = {31'b0, $signed(ex_rs1) < $signed(alu_b)};
            ALU_SLTU: alu_result = {31'b0, ex_rs1 < alu_b};
            ALU_SLL:  alu_result = ex_rs1 << alu_b[4:0];
            ALU_SRL:  alu_result = ex_rs1 >> alu_b[4:0];
            ALU_SRA:  alu_result = $signed(ex_rs1) >>> alu_b[4:0];
            default:  alu_result = alu_b;
        endcase
    end

    assign alu_zero     = (alu_result == 32'd0);
    assign alu_last_bit = alu_result[0];

    // Branch outcome from SUB zero flag or SLT/SLTU low bit
    always_comb begin
        case (ex_branch_f3)
            F3_BEQ:           taken = ex_branch && alu_zero;
            F3_BNE:           taken = ex_branch && !alu_zero;
            F3_BLT, F3_BLTU:  taken = ex_branch && alu_last_bit;
            F3_BGE, F3_BGEU:  taken = ex_branch && !alu_last_bit;
            default:          taken = 1'b0;
        endcase
    end

    // Second adder, also the U-type result
    always_comb begin
        case (ex_target_sel)
            TGT_ZERO: target_base = 32'd0;
            TGT_RS1:  target_base = ex_rs1;
            default:  target_base = ex_pc;
        endcase
    end

    assign target_sum = target_base + ex_imm;
    assign target     = (ex_target_sel == TGT_RS1) ? {target_sum[31:1], 1'b0} : target_sum;
    assign pc_plus4   = ex_pc + 32'd4;

    always_comb begin
        case (ex_wb_sel)
            WB_PC4:   wb_data = pc_plus4;
            WB_UPPER: wb_data = target_sum;
            default:  wb_data = alu_result;
        endcase
    end

    assign wb_en   = ex_valid && ex_reg_write;
    assign wb_addr = ex_rd;

    // Writeback report
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            reg_write    <= 1'b0;
            branch_taken <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            result_valid <= ex_valid;
            reg_write    <= wb_en;
            branch_taken <= ex_valid && taken;
            illegal      <= ex_valid && ex_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            result_rd   <= ex_rd;
            result_data <= wb_data;
            next_pc     <= (ex_jump || taken) ? target : pc_plus4;
        end
    end

endmodule

/* src/int_core_top.sv */
`timescale 1ns/10ps

module int_core_top
    import core_ctrl_pkg::*;
#(
    parameter int REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    output logic        result_valid,
    output logic [4:0]  result_rd,
    output logic [31:0] result_data,
    output logic        reg_write,
    output logic        branch_taken,
    output logic [31:0] next_pc,
    output logic        illegal
);

    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        ex_valid;
    logic        ex_illegal;
    alu_ctrl_e   ex_alu_ctrl;
    logic        ex_use_imm;
    logic [31:0] ex_imm;
    wb_sel_e     ex_wb_sel;
    target_sel_e ex_target_sel;
    logic        ex_branch;
    logic        ex_jump;
    logic [2:0]  ex_branch_f3;
    logic        ex_reg_write;
    logic [4:0]  ex_rd;
    logic [31:0] ex_pc;
    logic [31:0] ex_rs1;
    logic [31:0] ex_rs2;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    instr_decoder #(
        .REG_COUNT(REG_COUNT)
    ) i_decoder (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .ex_valid     (ex_valid),
        .ex_illegal   (ex_illegal),
        .ex_alu_ctrl  (ex_alu_ctrl),
        .ex_use_imm   (ex_use_imm),
        .ex_imm       (ex_imm),
        .ex_wb_sel    (ex_wb_sel),
        .ex_target_sel(ex_target_sel),
        .ex_branch    (ex_branch),
        .ex_jump      (ex_jump),
        .ex_branch_f3 (ex_branch_f3),
        .ex_reg_write (ex_reg_write),
        .ex_rd        (ex_rd),
        .ex_pc        (ex_pc),
        .ex_rs1       (ex_rs1),
        .ex_rs2       (ex_rs2)
    );

    reg_file #(
        .REG_COUNT(REG_COUNT)
    ) i_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    exec_unit i_exec (
        .clk          (clk),
        .reset        (reset),
        .ex_valid     (ex_valid),
        .ex_illegal   (ex_illegal),
        .ex_alu_ctrl  (ex_alu_ctrl),
        .ex_use_imm   (ex_use_imm),
        .ex_imm       (ex_imm),
        .ex_wb_sel    (ex_wb_sel),
        .ex_target_sel(ex_target_sel),
        .ex_branch    (ex_branch),
        .ex_jump      (ex_jump),
        .ex_branch_f3 (ex_branch_f3),
        .ex_reg_write (ex_reg_write),
        .ex_rd        (ex_rd),
        .ex_pc        (ex_pc),
        .ex_rs1       (ex_rs1),
        .ex_rs2       (ex_rs2),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data),
        .reg_write    (reg_write),
        .branch_taken (branch_taken),
        .next_pc      (next_pc),
        .illegal      (illegal)
    );

endmodule

/* test/tb_checker.sv */
`timescale 1ns/10ps

module tb_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [4:0]  exp_rd,
    input  logic [31:0] exp_data,
    input  logic        exp_wr,
    input  logic        exp_taken,
    input  logic [31:0] exp_npc,
    input  logic        exp_ill,
    input  logic        result_valid,
    input  logic [4:0]  result_rd,
    input  logic [31:0] result_data,
    input  logic        reg_write,
    input  logic        branch_taken,
    input  logic [31:0] next_pc,
    input  logic        illegal,
    output int          pass_count,
    output int          fail_count,
    output int          pending
);

    logic [31:0] q_instr [$];
    logic [4:0]  q_rd [$];
    logic [31:0] q_data [$];
    logic        q_wr [$];
    logic        q_taken [$];
    logic [31:0] q_npc [$];
    logic        q_ill [$];
    int          test_num;
    logic        ok;

    initial begin
        pass_count = 0;
        fail_count = 0;
        pending    = 0;
        test_num   = 0;
        ok         = 1'b1;
    end

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch at %0t: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            ok = 1'b0;
        end
    endtask

    // Oldest outstanding instruction owns each report
    always @(posedge clk) begin
        if (!reset && result_valid) begin
            if (q_instr.size() == 0) begin
                $display("Error at %0t: report arrived with no instruction outstanding",
                         $time);
                fail_count++;
            end else begin
                ok = 1'b1;
                test_num++;
                // rd and data only mean something when the instruction writes
                if (q_wr[0]) begin
                    check_field("result_rd", q_rd[0], result_rd);
                    check_field("result_data", q_data[0], result_data);
                end
                check_field("reg_write", q_wr[0], reg_write);
                check_field("branch_taken", q_taken[0], branch_taken);
                check_field("next_pc", q_npc[0], next_pc);
                check_field("illegal", q_ill[0], illegal);
                if (ok) begin
                    pass_count++;
                    $display("Test %0d (instr 0x%08h): pass", test_num, q_instr[0]);
                end else begin
                    fail_count++;
                    $display("Test %0d (instr 0x%08h): FAIL", test_num, q_instr[0]);
                end
                void'(q_instr.pop_front());
                void'(q_rd.pop_front());
                void'(q_data.pop_front());
                void'(q_wr.pop_front());
                void'(q_taken.pop_front());
                void'(q_npc.pop_front());
                void'(q_ill.pop_front());
            end
        end
        if (!reset && instr_valid) begin
            q_instr.push_back(instr);
            q_rd.push_back(exp_rd);
            q_data.push_back(exp_data);
            q_wr.push_back(exp_wr);
            q_taken.push_back(exp_taken);
            q_npc.push_back(exp_npc);
            q_ill.push_back(exp_ill);
        end
        pending = q_instr.size();
    end

endmodule

/* test/tb_int_core.sv */
`timescale 1ns/10ps

module tb_int_core;

    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        result_valid;
    logic [4:0]  result_rd;
    logic [31:0] result_data;
    logic        reg_write;
    logic        branch_taken;
    logic [31:0] next_pc;
    logic        illegal;

    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic        exp_wr;
    logic        exp_taken;
    logic [31:0] exp_npc;
    logic        exp_ill;
    int          pass_count;
    int          fail_count;
    int          pending;
    int unsigned seed_val;

    // Stimulus table, one entry per instruction
    logic [31:0] t_instr [$];
    logic [31:0] t_pc [$];
    logic [4:0]  t_rd [$];
    logic [31:0] t_data [$];
    logic        t_wr [$];
    logic        t_taken [$];
    logic [31:0] t_npc [$];
    logic        t_ill [$];

    int_core_top #(
        .REG_COUNT(32)
    ) i_dut (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .result_valid(result_valid),
        .result_rd   (result_rd),
        .result_data (result_data),
        .reg_write   (reg_write),
        .branch_taken(branch_taken),
        .next_pc     (next_pc),
        .illegal     (illegal)
    );

    tb_checker i_checker (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .exp_rd      (exp_rd),
        .exp_data    (exp_data),
        .exp_wr      (exp_wr),
        .exp_taken   (exp_taken),
        .exp_npc     (exp_npc),
        .exp_ill     (exp_ill),
        .result_valid(result_valid),
        .result_rd   (result_rd),
        .result_data (result_data),
        .reg_write   (reg_write),
        .branch_taken(branch_taken),
        .next_pc     (next_pc),
        .illegal     (illegal),
        .pass_count  (pass_count),
        .fail_count  (fail_count),
        .pending     (pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Instruction encoders, operands in assembly order
    function automatic logic [31:0] r_type(input int f3, input int f7, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] op, input int rd, input int imm);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic add_test(input logic [31:0] word, input logic [31:0] addr, input int rd,
                            input logic [31:0] data, input bit wr, input bit taken,
                            input logic [31:0] npc, input bit ill);
        t_instr.push_back(word);
        t_pc.push_back(addr);
        t_rd.push_back(rd[4:0]);
        t_data.push_back(data);
        t_wr.push_back(wr);
        t_taken.push_back(taken);
        t_npc.push_back(npc);
        t_ill.push_back(ill);
    endtask

    // Expected values follow from all registers starting at zero
    task automatic build_table();
        // Upper immediates
        add_test(u_type(OP_LUI, 1, 'h12345), 'h100, 1, 'h12345000, 1, 0, 'h104, 0);
        add_test(u_type(OP_AUIPC, 2, 'h1), 'h104, 2, 'h1104, 1, 0, 'h108, 0);
        // Register ALU ops, several back to back on fresh results
        add_test(i_type(OP_IMM, 0, 3, 0, 100), 'h108, 3, 'h64, 1, 0, 'h10C, 0);
        add_test(i_type(OP_IMM, 0, 4, 0, -7), 'h10C, 4, 'hFFFFFFF9, 1, 0, 'h110, 0);
        add_test(r_type(0, 0, 5, 3, 4), 'h110, 5, 'h5D, 1, 0, 'h114, 0);
        add_test(r_type(0, 'h20, 6, 3, 5), 'h114, 6, 'h7, 1, 0, 'h118, 0);
        add_test(r_type(7, 0, 7, 3, 4), 'h118, 7, 'h60, 1, 0, 'h11C, 0);
        add_test(r_type(6, 0, 8, 3, 6), 'h11C, 8, 'h67, 1, 0, 'h120, 0);
        add_test(r_type(4, 0, 9, 1, 4), 'h120, 9, 'hEDCBAFF9, 1, 0, 'h124, 0);
        add_test(r_type(2, 0, 10, 4, 3), 'h124, 10, 'h1, 1, 0, 'h128, 0);
        add_test(r_type(3, 0, 11, 4, 3), 'h128, 11, 'h0, 1, 0, 'h12C, 0);
        add_test(r_type(3, 0, 12, 3, 4), 'h12C, 12, 'h1, 1, 0, 'h130, 0);
        add_test(r_type(1, 0, 13, 6, 6), 'h130, 13, 'h380, 1, 0, 'h134, 0);
        add_test(r_type(5, 0, 14, 4, 6), 'h134, 14, 'h01FFFFFF, 1, 0, 'h138, 0);
        add_test(r_type(5, 'h20, 15, 4, 6), 'h138, 15, 'hFFFFFFFF, 1, 0, 'h13C, 0);
        // Immediate ALU ops
        add_test(i_type(OP_IMM, 1, 16, 3, 4), 'h13C, 16, 'h640, 1, 0, 'h140, 0);
        add_test(i_type(OP_IMM, 5, 17, 4, 'h401), 'h140, 17, 'hFFFFFFFC, 1, 0, 'h144, 0);
        add_test(i_type(OP_IMM, 5, 18, 1, 12), 'h144, 18, 'h12345, 1, 0, 'h148, 0);
        add_test(i_type(OP_IMM, 4, 19, 3, -1), 'h148, 19, 'hFFFFFF9B, 1, 0, 'h14C, 0);
        add_test(i_type(OP_IMM, 2, 20, 4, -6), 'h14C, 20, 'h1, 1, 0, 'h150, 0);
        add_test(i_type(OP_IMM, 3, 21, 3, -1), 'h150, 21, 'h1, 1, 0, 'h154, 0);
        add_test(i_type(OP_IMM, 7, 22, 4, 'hF0), 'h154, 22, 'hF0, 1, 0, 'h158, 0);
        add_test(i_type(OP_IMM, 6, 23, 6, 'h100), 'h158, 23, 'h107, 1, 0, 'h15C, 0);
        add_test(i_type(OP_IMM, 0, 24, 0, 5), 'h15C, 24, 'h5, 1, 0, 'h160, 0);
        add_test(r_type(0, 0, 25, 24, 24), 'h160, 25, 'hA, 1, 0, 'h164, 0);
        // Branches, each taken then not taken
        add_test(b_type(0, 3, 3, 16), 'h164, 0, 0, 0, 1, 'h174, 0);
        add_test(b_type(0, 3, 5, 16), 'h168, 0, 0, 0, 0, 'h16C, 0);
        add_test(b_type(1, 3, 5, -8), 'h16C, 0, 0, 0, 1, 'h164, 0);
        add_test(b_type(1, 0, 0, 8), 'h170, 0, 0, 0, 0, 'h174, 0);
        add_test(b_type(4, 4, 3, 32), 'h174, 0, 0, 0, 1, 'h194, 0);
        add_test(b_type(4, 3, 4, 32), 'h178, 0, 0, 0, 0, 'h17C, 0);
        add_test(b_type(5, 3, 4, -16), 'h17C, 0, 0, 0, 1, 'h16C, 0);
        add_test(b_type(5, 4, 3, 8), 'h180, 0, 0, 0, 0, 'h184, 0);
        add_test(b_type(6, 3, 4, 64), 'h184, 0, 0, 0, 1, 'h1C4, 0);
        add_test(b_type(6, 4, 3, 64), 'h188, 0, 0, 0, 0, 'h18C, 0);
        add_test(b_type(7, 4, 3, 12), 'h18C, 0, 0, 0, 1, 'h198, 0);
        add_test(b_type(7, 0, 3, 12), 'h190, 0, 0, 0, 0, 'h194, 0);
        // Jumps, JALR target 0x6B loses bit 0
        add_test(j_type(26, 256), 'h194, 26, 'h198, 1, 0, 'h294, 0);
        add_test(i_type(OP_JALR, 0, 27, 3, 7), 'h198, 27, 'h19C, 1, 0, 'h6A, 0);
        add_test(i_type(OP_JALR, 0, 28, 26, -4), 'h19C, 28, 'h1A0, 1, 0, 'h194, 0);
        // x0 keeps reading zero after a write
        add_test(i_type(OP_IMM, 0, 0, 3, 55), 'h1A0, 0, 'h9B, 1, 0, 'h1A4, 0);
        add_test(r_type(0, 0, 29, 0, 3), 'h1A4, 29, 'h64, 1, 0, 'h1A8, 0);
        // Rejected encodings, several aimed at x3
        add_test(i_type(OP_IMM, 1, 30, 3, 'h401), 'h1A8, 0, 0, 0, 0, 'h1AC, 1);
        add_test(i_type(OP_IMM, 5, 3, 3, 'h021), 'h1AC, 0, 0, 0, 0, 'h1B0, 1);
        add_test(i_type(OP_LOAD, 2, 3, 1, 4), 'h1B0, 0, 0, 0, 0, 'h1B4, 1);
        add_test(i_type(OP_STORE, 2, 3, 1, 5), 'h1B4, 0, 0, 0, 0, 'h1B8, 1);
        add_test(i_type(OP_SYSTEM, 1, 3, 1, 'h300), 'h1B8, 0, 0, 0, 0, 'h1BC, 1);
        add_test(r_type(0, 0, 31, 3, 0), 'h1BC, 31, 'h64, 1, 0, 'h1C0, 0);
    endtask

    initial begin
        seed_val    = $urandom(32'h7c8c);
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        exp_rd      = '0;
        exp_data    = '0;
        exp_wr      = 1'b0;
        exp_taken   = 1'b0;
        exp_npc     = '0;
        exp_ill     = 1'b0;
        build_table();

        fork
            begin
                repeat (t_instr.size() * 3 + 20) @(posedge clk);
                $display("Timeout: %0d reports never arrived", pending);
                $display("Test failures found");
                $finish;
            end
        join_none

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < t_instr.size(); i++) begin
            // Optional idle cycle between strobes
            if (i > 0 && ($urandom % 2) == 1) begin
                instr_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            instr_valid = 1'b1;
            instr       = t_instr[i];
            pc          = t_pc[i];
            exp_rd      = t_rd[i];
            exp_data    = t_data[i];
            exp_wr      = t_wr[i];
            exp_taken   = t_taken[i];
            exp_npc     = t_npc[i];
            exp_ill     = t_ill[i];
            @(posedge clk);
            #1;
        end
        instr_valid = 1'b0;

        wait (pending == 0);
        // Leave room for a stray report
        repeat (3) @(posedge clk);
        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count == t_instr.size()) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* int_core_top.f */
src/rv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/exec_unit.sv
src/int_core_top.sv
test/tb_checker.sv
test/tb_int_core.sv

/* Bender.yml */
package:
  name: int_core

sources:
  - src/rv_isa_pkg.sv
  - src/core_ctrl_pkg.sv
  - src/instr_decoder.sv
  - src/reg_file.sv
  - src/exec_unit.sv
  - src/int_core_top.sv
  - target: test
    files:
      - test/tb_checker.sv
      - test/tb_int_core.sv
